// File: flist.f
+incdir+include
source/motorPwmPkg.sv
source/motorCmdDecoder.sv
source/stepSequencer.sv
source/pwmPulseGenerator.sv
source/pwmLossMonitor.sv
source/motorPwmTop.sv
verification/motorPwmTb.sv

// File: include/motorPwm_consts.svh
`ifndef MOTORPWM_CONSTS_SVH
`define MOTORPWM_CONSTS_SVH

// period length, minimum width and per-period amount
`define MP_LEN_W 12

// carry and per-step totals
`define MP_SUM_W 16

// steps in one electrical cycle, the first half drives the high side
`define MP_STEPS 12

// periods-per-step count
`define MP_PERIODS_W 8

// configuration after reset
`define MP_DEF_LEN 256
`define MP_DEF_MIN 32
`define MP_DEF_AMOUNT 0
`define MP_DEF_PERIODS 4

`endif

// File: run.sh
#!/bin/sh
# build and run the motor PWM testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module motorPwmTb \
    -f flist.f

./obj_dir/VmotorPwmTb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation passed" sim.log; then
    exit 0
else
    exit 1
fi

// File: source/motorCmdDecoder.sv
`timescale 1ns/1ns
`include "motorPwm_consts.svh"

module motorCmdDecoder (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPwmPkg::commandT cmd,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    input  logic                 stepLast,
    output motorPwmPkg::configT  cfg,
    output logic                 run
);

    logic accept;
    logic timingOp;
    logic active;
    logic stepLastQ;

    // writes that change the step timing
    assign timingOp = (cmd.opcode == motorPwmPkg::SET_PERIOD) ||
                      (cmd.opcode == motorPwmPkg::SET_STEP_PERIODS);

    // while the sequencer runs these wait for the first cycle of the next step
    assign cmdReady = !(cmdValid && active && timingOp) || stepLastQ;
    assign accept   = cmdValid && cmdReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg.periodLen   <= `MP_DEF_LEN;
            cfg.minWidth    <= `MP_DEF_MIN;
            cfg.amount      <= `MP_DEF_AMOUNT;
            cfg.stepPeriods <= `MP_DEF_PERIODS;
            run             <= 1'b0;
        end else if (accept) begin
            case (cmd.opcode)
                motorPwmPkg::SET_PERIOD: begin
                    cfg.periodLen <= cmd.data[`MP_LEN_W-1:0];
                end
                motorPwmPkg::SET_MIN_WIDTH: begin
                    cfg.minWidth <= cmd.data[`MP_LEN_W-1:0];
                end
                motorPwmPkg::SET_AMOUNT: begin
                    cfg.amount <= cmd.data[`MP_LEN_W-1:0];
                end
                motorPwmPkg::SET_STEP_PERIODS: begin
                    cfg.stepPeriods <= cmd.data[`MP_PERIODS_W-1:0];
                end
                motorPwmPkg::START: begin
                    run <= 1'b1;
                end
                motorPwmPkg::STOP: begin
                    run <= 1'b0;
                end
                default: begin
                end
            endcase
        end
    end

    // follows the sequencer, busy from START until a step ends with run low
    always_ff @(posedge clk) begin
        if (reset) begin
            active    <= 1'b0;
            stepLastQ <= 1'b0;
        end else begin
            stepLastQ <= stepLast;
            if (accept && cmd.opcode == motorPwmPkg::START) begin
                active <= 1'b1;
            end else if (stepLast && !run) begin
                active <= 1'b0;
            end
        end
    end

    // timing fields change only right after a step boundary while running
    cfgHeldInStep: assert property (@(posedge clk) disable iff (reset)
        (active && !stepLastQ) |=> ($stable(cfg.periodLen) && $stable(cfg.stepPeriods)));

endmodule

// File: source/motorPwmPkg.sv
package motorPwmPkg;

`include "motorPwm_consts.svh"

    // host command opcodes
    typedef enum logic [2:0] {
        SET_PERIOD       = 3'd0,
        SET_MIN_WIDTH    = 3'd1,
        SET_AMOUNT       = 3'd2,
        SET_STEP_PERIODS = 3'd3,
        START            = 3'd4,
        STOP             = 3'd5
    } opcodeT;

    typedef enum logic {
        IDLE = 1'b0,
        RUN  = 1'b1
    } seqStateT;

    typedef struct packed {
        opcodeT      opcode;
        logic [15:0] data;
    } commandT;

    typedef struct packed {
        logic [`MP_LEN_W-1:0]     periodLen;
        logic [`MP_LEN_W-1:0]     minWidth;
        logic [`MP_LEN_W-1:0]     amount;
        logic [`MP_PERIODS_W-1:0] stepPeriods;
    } configT;

    // per-cycle flags from the step sequencer
    typedef struct packed {
        logic       running;
        logic       periodStart;
        logic       stepFirst;
        logic       stepLast;
        logic [3:0] step;
        logic       highSide;
    } timingT;

    // end-of-step loss report
    typedef struct packed {
        logic [3:0]           step;
        logic [`MP_SUM_W-1:0] wantSum;
        logic [`MP_SUM_W-1:0] realSum;
        logic [`MP_SUM_W-1:0] lost;
    } reportT;

endpackage

// File: source/motorPwmTop.sv
`timescale 1ns/1ns
`include "motorPwm_consts.svh"

module motorPwmTop (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPwmPkg::commandT cmd,
    input  logic                 cmdValid,
    output logic                 cmdReady,
    output logic                 pwm,
    output motorPwmPkg::reportT  report,
    output logic                 resValid,
    input  logic                 resReady,
    output logic                 overrun
);

    motorPwmPkg::configT  cfg;
    motorPwmPkg::timingT  timing;
    logic                 run;
    logic                 periodDone;
    logic [`MP_LEN_W-1:0] width;
    logic [`MP_LEN_W-1:0] amount;

    // decode
    motorCmdDecoder i_motorCmdDecoder (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .stepLast (timing.stepLast),
        .cfg      (cfg),
        .run      (run)
    );

    // execute
    stepSequencer i_stepSequencer (
        .clk    (clk),
        .reset  (reset),
        .cfg    (cfg),
        .run    (run),
        .timing (timing)
    );

    pwmPulseGenerator i_pwmPulseGenerator (
        .clk        (clk),
        .reset      (reset),
        .cfg        (cfg),
        .timing     (timing),
        .pwm        (pwm),
        .periodDone (periodDone),
        .width      (width),
        .amount     (amount)
    );

    // result
    pwmLossMonitor i_pwmLossMonitor (
        .clk        (clk),
        .reset      (reset),
        .timing     (timing),
        .periodDone (periodDone),
        .width      (width),
        .amount     (amount),
        .report     (report),
        .resValid   (resValid),
        .resReady   (resReady),
        .overrun    (overrun)
    );

endmodule

// File: source/pwmLossMonitor.sv
`timescale 1ns/1ns
`include "motorPwm_consts.svh"

module pwmLossMonitor (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPwmPkg::timingT  timing,
    input  logic                 periodDone,
    input  logic [`MP_LEN_W-1:0] width,
    input  logic [`MP_LEN_W-1:0] amount,
    output motorPwmPkg::reportT  report,
    output logic                 resValid,
    input  logic                 resReady,
    output logic                 overrun
);

    localparam int PAD_W = `MP_SUM_W - `MP_LEN_W;

    logic [`MP_SUM_W-1:0] wantAcc;
    logic [`MP_SUM_W-1:0] realAcc;
    logic [`MP_SUM_W-1:0] wantNow;
    logic [`MP_SUM_W-1:0] realNow;
    logic                 canLoad;

    // totals including a period that closes in this very cycle
    assign wantNow = wantAcc + (periodDone ? {{PAD_W{1'b0}}, amount} : {`MP_SUM_W{1'b0}});
    assign realNow = realAcc + (periodDone ? {{PAD_W{1'b0}}, width} : {`MP_SUM_W{1'b0}});

    // the report slot is free or is handed over in this cycle
    assign canLoad = !resValid || resReady;

    always_ff @(posedge clk) begin
        if (reset) begin
            wantAcc  <= '0;
            realAcc  <= '0;
            resValid <= 1'b0;
            overrun  <= 1'b0;
        end else begin
            if (timing.stepLast) begin
                wantAcc <= '0;
                realAcc <= '0;
            end else if (periodDone) begin
                wantAcc <= wantNow;
                realAcc <= realNow;
            end
            if (timing.stepLast && canLoad) begin
                resValid <= 1'b1;
            end else if (resReady) begin
                resValid <= 1'b0;
            end
            // sticky, the dropped report is gone for good
            if (timing.stepLast && !canLoad) begin
                overrun <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (timing.stepLast && canLoad) begin
            report.step    <= timing.step;
            report.wantSum <= wantNow;
            report.realSum <= realNow;
            report.lost    <= wantNow - realNow;
        end
    end

endmodule

// File: source/pwmPulseGenerator.sv
`timescale 1ns/1ns
`include "motorPwm_consts.svh"

module pwmPulseGenerator (
    input  logic                 clk,
    input  logic                 reset,
    input  motorPwmPkg::configT  cfg,
    input  motorPwmPkg::timingT  timing,
    output logic                 pwm,
    output logic                 periodDone,
    output logic [`MP_LEN_W-1:0] width,
    output logic [`MP_LEN_W-1:0] amount
);

    localparam int PAD_W = `MP_SUM_W - `MP_LEN_W;

    logic [`MP_SUM_W-1:0] carry;
    logic [`MP_SUM_W-1:0] carryIn;
    logic [`MP_SUM_W-1:0] pending;
    logic [`MP_SUM_W-1:0] minWide;
    logic [`MP_SUM_W-1:0] capWide;
    logic [`MP_LEN_W-1:0] capLen;
    logic [`MP_LEN_W-1:0] capNow;
    logic [`MP_LEN_W-1:0] widthNext;
    logic [`MP_LEN_W-1:0] pulseCnt;
    logic                 fits;

    // a new step starts from an empty carry
    assign carryIn = timing.stepFirst ? {`MP_SUM_W{1'b0}} : carry;
    assign pending = carryIn + {{PAD_W{1'b0}}, cfg.amount};

    // longest pulse that still leaves one low cycle in the period
    assign capNow  = timing.stepFirst ? cfg.periodLen - 1'b1 : capLen;
    assign capWide = {{PAD_W{1'b0}}, capNow};
    assign minWide = {{PAD_W{1'b0}}, cfg.minWidth};

    // below the minimum nothing is emitted and the whole sum is deferred
    assign fits = (pending >= minWide);

    always_comb begin
        if (!fits) begin
            widthNext = '0;
        end else if (pending > capWide) begin
            widthNext = capNow;
        end else begin
            widthNext = pending[`MP_LEN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            carry      <= '0;
            pulseCnt   <= '0;
            periodDone <= 1'b0;
        end else begin
            periodDone <= timing.periodStart;
            if (timing.periodStart) begin
                // what did not fit in this period moves on to the next one
                carry    <= pending - {{PAD_W{1'b0}}, widthNext};
                pulseCnt <= widthNext;
            end else if (pulseCnt != '0) begin
                pulseCnt <= pulseCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (timing.periodStart) begin
            width  <= widthNext;
            amount <= cfg.amount;
        end
        if (timing.stepFirst) begin
            capLen <= cfg.periodLen - 1'b1;
        end
    end

    // high for width cycles from the cycle after periodStart
    assign pwm = (pulseCnt != '0);

    // every pulse is over before the next period begins
    pulseInPeriod: assert property (@(posedge clk) disable iff (reset)
        timing.periodStart |-> (pulseCnt == '0));

endmodule

// File: source/stepSequencer.sv
`timescale 1ns/1ns
`include "motorPwm_consts.svh"

module stepSequencer (
    input  logic                clk,
    input  logic                reset,
    input  motorPwmPkg::configT cfg,
    input  logic                run,
    output motorPwmPkg::timingT timing
);

    motorPwmPkg::seqStateT    state;
    logic [`MP_LEN_W-1:0]     periodCnt;
    logic [`MP_PERIODS_W-1:0] periodIdx;
    logic [3:0]               step;
    logic [`MP_LEN_W-1:0]     lenQ;
    logic [`MP_PERIODS_W-1:0] periodsQ;
    logic                     startQ;
    logic                     active;
    logic                     periodLast;
    logic                     stepEnd;
    logic                     stepLast;

    // a run request seen in IDLE is already the first cycle of step 0
    assign active     = (state == motorPwmPkg::RUN) || run;
    assign periodLast = (periodCnt == '0);
    assign stepEnd    = (periodIdx == periodsQ - 1'b1);
    assign stepLast   = active && periodLast && stepEnd;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= motorPwmPkg::IDLE;
            startQ    <= 1'b1;
            periodCnt <= '0;
            periodIdx <= '0;
            step      <= '0;
        end else if (!active || (stepLast && !run)) begin
            // idle, or stopped at a step boundary: keep step 0 preloaded
            state     <= motorPwmPkg::IDLE;
            startQ    <= 1'b1;
            periodCnt <= cfg.periodLen - 1'b1;
            periodIdx <= '0;
            step      <= '0;
        end else begin
            state  <= motorPwmPkg::RUN;
            startQ <= periodLast;
            if (!periodLast) begin
                periodCnt <= periodCnt - 1'b1;
            end else if (stepEnd) begin
                periodCnt <= cfg.periodLen - 1'b1;
                periodIdx <= '0;
                step      <= (step == `MP_STEPS - 1) ? 4'd0 : step + 1'b1;
            end else begin
                periodCnt <= lenQ - 1'b1;
                periodIdx <= periodIdx + 1'b1;
            end
        end
    end

    // period length and step length are taken once per step
    always_ff @(posedge clk) begin
        if (!active || stepLast) begin
            lenQ     <= cfg.periodLen;
            periodsQ <= cfg.stepPeriods;
        end
    end

    assign timing.running     = active;
    assign timing.periodStart = active && startQ;
    assign timing.stepFirst   = active && startQ && (periodIdx == '0);
    assign timing.stepLast    = stepLast;
    assign timing.step        = step;
    assign timing.highSide    = (step < `MP_STEPS / 2);

    stepInRange: assert property (@(posedge clk) disable iff (reset)
        step < `MP_STEPS);

    // the period counter never runs past the latched period length
    periodInRange: assert property (@(posedge clk) disable iff (reset)
        timing.running |-> (periodCnt < lenQ));

endmodule

// File: verification/motorPwmTb.sv
`timescale 1ns/1ns
`include "motorPwm_consts.svh"

module motorPwmTb;

    logic                 clk;
    logic                 reset;
    motorPwmPkg::commandT cmd;
    logic                 cmdValid;
    logic                 cmdReady;
    logic                 pwm;
    motorPwmPkg::reportT  report;
    logic                 resValid;
    logic                 resReady;
    logic                 overrun;
    motorPwmPkg::timingT  tim;
    motorPwmPkg::reportT  heldReport;

    integer seed = 79377;
    int     curLen;
    int     curMin;
    int     curAmt;
    int     curPer;
    int     expStep;
    int     reportsSeen;
    int     periodIdx;
    int     periodHigh;
    int     stepHigh;
    int     stepNum;
    bit     inPeriod;
    bit     checkReports;
    bit     checkPeriods;
    int     stepHighQ[$];

    motorPwmTop i_motorPwmTop (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .cmdValid (cmdValid),
        .cmdReady (cmdReady),
        .pwm      (pwm),
        .report   (report),
        .resValid (resValid),
        .resReady (resReady),
        .overrun  (overrun)
    );

    // step boundaries come from the sequencer inside the DUT
    assign tim = i_motorPwmTop.timing;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopped after the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1, "stopped after the first error");
        end
    endtask

    // pulse width for one period given the pending sum
    function automatic int widthFor(input int len, input int mn, input int pend);
        if (pend < mn) begin
            return 0;
        end
        return (pend > len - 1) ? len - 1 : pend;
    endfunction

    function automatic int expectedWidth(input int len, input int mn, input int amt,
                                         input int idx);
        int carry;
        int pend;
        int w;
        carry = 0;
        w = 0;
        for (int i = 0; i <= idx; i++) begin
            pend = carry + amt;
            w = widthFor(len, mn, pend);
            carry = pend - w;
        end
        return w;
    endfunction

    function automatic motorPwmPkg::reportT refReport(input int len, input int mn,
                                                      input int amt, input int per);
        motorPwmPkg::reportT r;
        int carry;
        int pend;
        int w;
        int want;
        int got;
        carry = 0;
        want = 0;
        got = 0;
        for (int i = 0; i < per; i++) begin
            pend = carry + amt;
            w = widthFor(len, mn, pend);
            carry = pend - w;
            want += amt;
            got += w;
        end
        r.step    = 4'd0;
        r.wantSum = 16'(want);
        r.realSum = 16'(got);
        r.lost    = 16'(want - got);
        return r;
    endfunction

    // pwm high cycles per period and per step
    always @(negedge clk) begin
        if (reset || !tim.running) begin
            inPeriod = 1'b0;
        end else if (tim.periodStart) begin
            if (inPeriod && checkPeriods) begin
                checkValue("pwm high per period", 32'(periodHigh),
                           32'(expectedWidth(curLen, curMin, curAmt, periodIdx)));
            end
            if (tim.stepFirst) begin
                stepNum = inPeriod ? (stepNum + 1) % `MP_STEPS : 0;
                checkValue("timing.step", 32'(tim.step), 32'(stepNum));
                // steps 0 to 5 drive the high side
                checkValue("timing.highSide", 32'(tim.highSide), 32'(stepNum <= 5));
            end
            periodIdx = tim.stepFirst ? 0 : periodIdx + 1;
            periodHigh = 0;
            inPeriod = 1'b1;
        end
        if (!reset && pwm) begin
            periodHigh++;
            stepHigh++;
        end
        if (!reset && tim.stepLast) begin
            stepHighQ.push_back(stepHigh);
            stepHigh = 0;
        end
    end

    // compare every accepted report with the reference
    always @(negedge clk) begin
        motorPwmPkg::reportT exp;
        if (!reset && resValid && resReady) begin
            reportsSeen++;
            if (checkReports) begin
                exp = refReport(curLen, curMin, curAmt, curPer);
                checkValue("report.step", 32'(report.step), 32'(expStep));
                checkValue("report.wantSum", 32'(report.wantSum), 32'(exp.wantSum));
                checkValue("report.realSum", 32'(report.realSum), 32'(exp.realSum));
                checkValue("report.lost", 32'(report.lost), 32'(exp.lost));
                if (stepHighQ.size() == 0) begin
                    failRun("report arrived before its step ended");
                end
                checkValue("pwm high per step", 32'(stepHighQ.pop_front()),
                           32'(exp.realSum));
                expStep = (expStep + 1) % `MP_STEPS;
            end
        end
    end

    task automatic sendCmd(input motorPwmPkg::opcodeT op, input logic [15:0] data);
        int n;
        @(posedge clk);
        #1;
        cmd.opcode = op;
        cmd.data = data;
        cmdValid = 1'b1;
        n = 0;
        @(negedge clk);
        while (!cmdReady) begin
            n++;
            if (n > 5000) begin
                failRun("timed out waiting for cmdReady");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        cmdValid = 1'b0;
    endtask

    task automatic waitIdle(input int limit);
        int n;
        n = 0;
        while (tim.running) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                failRun("sequencer did not stop");
            end
        end
    endtask

    task automatic runScenario(input int len, input int mn, input int amt, input int per,
                               input int steps);
        int n;
        int limit;
        limit = (steps + 2) * per * len + 200;
        sendCmd(motorPwmPkg::SET_PERIOD, 16'(len));
        sendCmd(motorPwmPkg::SET_MIN_WIDTH, 16'(mn));
        sendCmd(motorPwmPkg::SET_AMOUNT, 16'(amt));
        sendCmd(motorPwmPkg::SET_STEP_PERIODS, 16'(per));
        curLen = len;
        curMin = mn;
        curAmt = amt;
        curPer = per;
        expStep = 0;
        reportsSeen = 0;
        stepHigh = 0;
        stepHighQ.delete();
        checkReports = 1'b1;
        checkPeriods = 1'b1;
        sendCmd(motorPwmPkg::START, 16'd0);
        n = 0;
        while (reportsSeen < steps) begin
            @(negedge clk);
            n++;
            if (n > limit) begin
                failRun("timed out waiting for step reports");
            end
        end
        sendCmd(motorPwmPkg::STOP, 16'd0);
        waitIdle(2 * per * len + 50);
        n = 0;
        while (resValid) begin
            @(negedge clk);
            n++;
            if (n > 50) begin
                failRun("last report was not taken");
            end
        end
        // once stopped nothing moves
        for (int i = 0; i < 2 * len + 20; i++) begin
            @(negedge clk);
            checkValue("pwm", 32'(pwm), 32'd0);
            checkValue("resValid", 32'(resValid), 32'd0);
        end
    endtask

    initial begin
        motorPwmPkg::reportT bpExp;
        int len;
        int mn;
        int amt;
        int per;
        int n;
        reset = 1'b1;
        cmd = '0;
        cmdValid = 1'b0;
        resReady = 1'b1;
        checkReports = 1'b0;
        checkPeriods = 1'b0;
        stepHigh = 0;
        stepNum = 0;
        periodHigh = 0;
        periodIdx = 0;
        inPeriod = 1'b0;
        reportsSeen = 0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        checkValue("cmdReady", 32'(cmdReady), 32'd1);
        checkValue("overrun", 32'(overrun), 32'd0);
        checkValue("pwm", 32'(pwm), 32'd0);
        checkValue("resValid", 32'(resValid), 32'd0);

        // default timing, amount above the minimum
        runScenario(`MP_DEF_LEN, `MP_DEF_MIN, 100, `MP_DEF_PERIODS, `MP_STEPS);
        // amount below the minimum, deferred pulses
        runScenario(64, 32, 10, 5, 3);
        // amount beyond the period, capped widths
        runScenario(32, 8, 50, 4, 3);
        for (int r = 0; r < 4; r++) begin
            len = 16 + int'($unsigned($random(seed)) % 64);
            mn = 1 + int'($unsigned($random(seed)) % len);
            amt = int'($unsigned($random(seed)) % (2 * len));
            per = 1 + int'($unsigned($random(seed)) % 6);
            runScenario(len, mn, amt, per, 3);
        end

        // back-pressure on the result port
        checkReports = 1'b0;
        checkPeriods = 1'b0;
        sendCmd(motorPwmPkg::SET_PERIOD, 16'd40);
        sendCmd(motorPwmPkg::SET_MIN_WIDTH, 16'd4);
        sendCmd(motorPwmPkg::SET_AMOUNT, 16'd20);
        sendCmd(motorPwmPkg::SET_STEP_PERIODS, 16'd3);
        resReady = 1'b0;
        sendCmd(motorPwmPkg::START, 16'd0);
        n = 0;
        while (!resValid) begin
            @(negedge clk);
            n++;
            if (n > 400) begin
                failRun("no report under back-pressure");
            end
        end
        heldReport = report;
        bpExp = refReport(40, 4, 20, 3);
        checkValue("report.step", 32'(heldReport.step), 32'd0);
        checkValue("report.wantSum", 32'(heldReport.wantSum), 32'(bpExp.wantSum));
        checkValue("report.realSum", 32'(heldReport.realSum), 32'(bpExp.realSum));
        checkValue("report.lost", 32'(heldReport.lost), 32'(bpExp.lost));
        n = 0;
        while (!overrun) begin
            @(negedge clk);
            checkValue("resValid", 32'(resValid), 32'd1);
            checkValue("report.wantSum", 32'(report.wantSum), 32'(heldReport.wantSum));
            checkValue("report.realSum", 32'(report.realSum), 32'(heldReport.realSum));
            checkValue("report.lost", 32'(report.lost), 32'(heldReport.lost));
            checkValue("report.step", 32'(report.step), 32'(heldReport.step));
            n++;
            if (n > 400) begin
                failRun("overrun did not rise");
            end
        end

        // timing write while running waits for a step start
        @(posedge clk);
        #1;
        cmd.opcode = motorPwmPkg::SET_PERIOD;
        cmd.data = 16'd48;
        cmdValid = 1'b1;
        @(negedge clk);
        checkValue("cmdReady", 32'(cmdReady), 32'd0);
        n = 0;
        while (!cmdReady) begin
            @(negedge clk);
            n++;
            if (n > 400) begin
                failRun("SET_PERIOD was never accepted");
            end
        end
        checkValue("stepFirst at accept", 32'(tim.stepFirst), 32'd1);
        @(posedge clk);
        #1;
        cmdValid = 1'b0;
        // the new length shows from the following step boundary
        n = 0;
        @(negedge clk);
        while (!(tim.periodStart && tim.stepFirst)) begin
            @(negedge clk);
            n++;
            if (n > 400) begin
                failRun("next step did not start");
            end
        end
        n = 0;
        @(negedge clk);
        n++;
        while (!tim.periodStart) begin
            @(negedge clk);
            n++;
            if (n > 400) begin
                failRun("period did not end");
            end
        end
        checkValue("period length", 32'(n), 32'd48);
        @(posedge clk);
        #1;
        resReady = 1'b1;
        sendCmd(motorPwmPkg::STOP, 16'd0);
        waitIdle(500);
        checkValue("overrun", 32'(overrun), 32'd1);

        $display("Simulation passed");
        $finish;
    end

endmodule
